/* flist.f */
+incdir+hw
hw/hci_req_pkg.sv
hw/hci_resp_pkg.sv
hw/hci_core_mux_static.sv
hw/tcdm_bank_router.sv
hw/tcdm_bank.sv
hw/tcdm_resp_merge.sv
hw/tcdm_subsystem.sv
tb/tb_tcdm_subsystem.sv

/* hw/hci_core_mux_static.sv */
`include "hci_params.svh"

// Static multiplexer between initiator ports that are used strictly one at a time.
// No arbitration happens here. The sel_i level alone picks the active port.
module hci_core_mux_static (
  input  logic [$clog2(`HCI_NB_CHAN)-1:0]            sel_i,         // Active initiator.
  input  logic [`HCI_NB_CHAN-1:0]                    in_req_i,
  input  logic [`HCI_NB_CHAN-1:0][`HCI_AW-1:0]       in_add_i,
  input  logic [`HCI_NB_CHAN-1:0]                    in_wen_i,      // 1 is read.
  input  logic [`HCI_NB_CHAN-1:0][`HCI_DW-1:0]       in_data_i,
  input  hci_req_pkg::tcdm_be_t [`HCI_NB_CHAN-1:0]   in_be_i,
  input  logic [`HCI_NB_CHAN-1:0][`HCI_UW-1:0]       in_user_i,
  output logic [`HCI_NB_CHAN-1:0]                    in_gnt_o,
  output logic [`HCI_NB_CHAN-1:0]                    in_r_valid_o,
  output logic [`HCI_NB_CHAN-1:0][`HCI_DW-1:0]       in_r_data_o,
  output hci_resp_pkg::tcdm_opc_e [`HCI_NB_CHAN-1:0] in_r_opc_o,
  output logic [`HCI_NB_CHAN-1:0][`HCI_UW-1:0]       in_r_user_o,
  input  logic                                       r_valid_i,     // From the merger.
  input  logic [`HCI_DW-1:0]                         r_data_i,
  input  hci_resp_pkg::tcdm_opc_e                    r_opc_i,
  input  logic [`HCI_UW-1:0]                         r_user_i,
  output logic                                       out_req_o,     // Towards the router.
  output logic [`HCI_AW-1:0]                         out_add_o,
  output logic                                       out_wen_o,
  output logic [`HCI_DW-1:0]                         out_data_o,
  output hci_req_pkg::tcdm_be_t                      out_be_o,
  output logic [`HCI_UW-1:0]                         out_user_o
);

  for (genvar ii = 0; ii < `HCI_NB_CHAN; ii++) begin : gen_chan
    // The banks never stall, so the active port is granted whenever it asks.
    // The idle port keeps a low grant and holds its request.
    assign in_gnt_o[ii]     = (sel_i == ii) ? in_req_i[ii] : 1'b0;
    assign in_r_valid_o[ii] = (sel_i == ii) ? r_valid_i    : 1'b0;  // Only the owner sees it.

    // Response payload goes to everyone.
    // Only the strobe tells a port the response is its own.
    assign in_r_data_o[ii] = r_data_i;
    assign in_r_opc_o[ii]  = r_opc_i;
    assign in_r_user_o[ii] = r_user_i;
  end

  // Request side is a plain indexed select on the active port.
  assign out_req_o  = in_req_i[sel_i];
  assign out_add_o  = in_add_i[sel_i];
  assign out_wen_o  = in_wen_i[sel_i];
  assign out_data_o = in_data_i[sel_i];
  assign out_be_o   = in_be_i[sel_i];
  assign out_user_o = in_user_i[sel_i];

endmodule

/* hw/hci_params.svh */
`ifndef HCI_PARAMS_SVH
`define HCI_PARAMS_SVH

// Number of initiator ports that share the single memory path.
`define HCI_NB_CHAN 2

// Width of one data word in bits.
`define HCI_DW 32

// Width of the byte address produced by the initiators.
`define HCI_AW 32

// Width of the user tag that is echoed back with every response.
`define HCI_UW 4

// One byte-enable bit per byte of the data word.
`define HCI_BE_W 4

// Number of word-interleaved banks behind the router.
`define HCI_NB_BANKS 4

// Words held by each bank, so the whole memory is NB_BANKS * BANK_DEPTH words.
`define HCI_BANK_DEPTH 64

`endif

/* hw/hci_req_pkg.sv */
`include "hci_params.svh"

package hci_req_pkg;

  // Field widths of a byte address as the banks see it.
  localparam int unsigned OFFSET_W = $clog2(`HCI_BE_W);       // Byte inside a word.
  localparam int unsigned BANK_W   = $clog2(`HCI_NB_BANKS);   // Bank index.
  localparam int unsigned ROW_W    = $clog2(`HCI_BANK_DEPTH); // Word inside a bank.
  localparam int unsigned UPPER_W  = `HCI_AW - ROW_W - BANK_W - OFFSET_W;

  // The bank index sits right above the byte offset.
  // Consecutive words therefore land in consecutive banks.
  typedef struct packed {
    logic [UPPER_W-1:0]  upper;   // Must be zero, anything else is out of range.
    logic [ROW_W-1:0]    row;     // Word address inside the bank.
    logic [BANK_W-1:0]   bank;    // Which bank takes the access.
    logic [OFFSET_W-1:0] offset;  // Must be zero for a word-aligned access.
  } tcdm_addr_fld_t;

  // Same address word seen two ways.
  // The initiators write the flat byte address.
  // The router reads it back through the field view.
  typedef union packed {
    logic [`HCI_AW-1:0] flat;
    tcdm_addr_fld_t     fld;
  } tcdm_addr_t;

  // One bit per byte lane of the data word.
  typedef logic [`HCI_BE_W-1:0] tcdm_be_t;

endpackage

/* hw/hci_resp_pkg.sv */
package hci_resp_pkg;

  // Response opcode returned with every r_valid pulse.
  // OPC_ERR flags an access that was misaligned or out of range.
  // Such an access never reached a bank.
  typedef enum logic {
    OPC_OK  = 1'b0,  // Normal read or write completion.
    OPC_ERR = 1'b1   // Bad address with a zero data field.
  } tcdm_opc_e;

endpackage

/* hw/tcdm_bank.sv */
`include "hci_params.svh"

// One word-wide memory bank with byte-enabled writes.
// Every request, read or write, gets a response one cycle later.
module tcdm_bank #(
  parameter int unsigned DEPTH = `HCI_BANK_DEPTH  // Number of words held.
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    clear_i,
  input  logic                                    req_i,
  input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] row_i,
  input  logic                                    wen_i,     // 1 is read, 0 is write.
  input  logic [`HCI_DW-1:0]                      data_i,
  input  hci_req_pkg::tcdm_be_t                   be_i,
  input  logic [`HCI_UW-1:0]                      user_i,
  output logic                                    r_valid_o,
  output logic [`HCI_DW-1:0]                      r_data_o,
  output logic [`HCI_UW-1:0]                      r_user_o
);

  logic [`HCI_DW-1:0] mem [DEPTH];  // Word storage.
  logic               r_valid_q;
  logic [`HCI_DW-1:0] r_data_q;
  logic [`HCI_UW-1:0] r_user_q;

  // Only the byte lanes whose enable is set are written.
  always_ff @(posedge clk_i) begin
    if (req_i && !wen_i) begin
      for (int b = 0; b < `HCI_BE_W; b++) begin
        if (be_i[b]) begin
          mem[row_i][8*b +: 8] <= data_i[8*b +: 8];
        end
      end
    end
  end

  // Read data is sampled before the write of the same edge lands.
  // Writes answer with a zero data word.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      r_data_q <= wen_i ? mem[row_i] : '0;
      r_user_q <= user_i;  // Echoed unchanged.
    end
  end

  // Response strobe is the only control state in the bank.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else if (clear_i) begin
      r_valid_q <= 1'b0;  // Pending response is lost, memory keeps its contents.
    end else begin
      r_valid_q <= req_i;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_user_o  = r_user_q;

endmodule

/* hw/tcdm_bank_router.sv */
`include "hci_params.svh"

// Splits the word address into bank and row and strobes exactly one bank.
// Bad addresses never reach a bank. They get a locally generated error response instead.
module tcdm_bank_router (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              clear_i,
  input  logic                              req_i,        // Already granted upstream.
  input  hci_req_pkg::tcdm_addr_t           add_i,
  input  logic                              wen_i,
  input  logic [`HCI_DW-1:0]                data_i,
  input  hci_req_pkg::tcdm_be_t             be_i,
  input  logic [`HCI_UW-1:0]                user_i,
  output logic [`HCI_NB_BANKS-1:0]          bank_req_o,   // One-hot or all zero.
  output logic [hci_req_pkg::ROW_W-1:0]     bank_row_o,
  output logic                              bank_wen_o,
  output logic [`HCI_DW-1:0]                bank_data_o,
  output hci_req_pkg::tcdm_be_t             bank_be_o,
  output logic [`HCI_UW-1:0]                bank_user_o,
  output logic                              err_valid_o,  // One cycle after the bad request.
  output logic [`HCI_UW-1:0]                err_user_o
);

  logic               addr_bad;
  logic               err_valid_q;
  logic [`HCI_UW-1:0] err_user_q;

  // Any upper bit set is out of range. Any offset bit set is misaligned.
  assign addr_bad = (|add_i.fld.upper) | (|add_i.fld.offset);

  // Decode the bank field into a strobe only for good addresses.
  always_comb begin
    bank_req_o = '0;
    if (req_i && !addr_bad) begin
      bank_req_o[add_i.fld.bank] = 1'b1;
    end
  end

  // The remaining request lines are shared by all banks.
  assign bank_row_o  = add_i.fld.row;
  assign bank_wen_o  = wen_i;
  assign bank_data_o = data_i;
  assign bank_be_o   = be_i;
  assign bank_user_o = user_i;

  // Error strobe is registered so that it lines up with the bank read latency.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_valid_q <= 1'b0;
    end else if (clear_i) begin
      err_valid_q <= 1'b0;  // A pending error response is dropped.
    end else begin
      err_valid_q <= req_i & addr_bad;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && addr_bad) begin
      err_user_q <= user_i;  // Tag travels with the error pulse.
    end
  end

  assign err_valid_o = err_valid_q;
  assign err_user_o  = err_user_q;

endmodule

/* hw/tcdm_resp_merge.sv */
`include "hci_params.svh"

// Folds the bank responses and the router error response into one stream.
// At most one source is valid in a cycle, because only one request is accepted per cycle.
module tcdm_resp_merge (
  input  logic [`HCI_NB_BANKS-1:0]              b_r_valid_i,
  input  logic [`HCI_NB_BANKS-1:0][`HCI_DW-1:0] b_r_data_i,
  input  logic [`HCI_NB_BANKS-1:0][`HCI_UW-1:0] b_r_user_i,
  input  logic                                  err_valid_i,  // From the router.
  input  logic [`HCI_UW-1:0]                    err_user_i,
  output logic                                  r_valid_o,
  output logic [`HCI_DW-1:0]                    r_data_o,
  output hci_resp_pkg::tcdm_opc_e               r_opc_o,
  output logic [`HCI_UW-1:0]                    r_user_o
);

  // A response exists when any bank or the error path speaks.
  assign r_valid_o = (|b_r_valid_i) | err_valid_i;

  // Error path has no data, so an error response carries a zero word.
  assign r_opc_o = err_valid_i ? hci_resp_pkg::OPC_ERR : hci_resp_pkg::OPC_OK;

  // AND-OR merge of the sources.
  // Idle sources contribute zero, so the payload is zero when nothing is valid.
  always_comb begin
    r_data_o = '0;
    r_user_o = err_valid_i ? err_user_i : '0;
    for (int b = 0; b < `HCI_NB_BANKS; b++) begin
      if (b_r_valid_i[b]) begin
        r_data_o = r_data_o | b_r_data_i[b];
        r_user_o = r_user_o | b_r_user_i[b];
      end
    end
  end

endmodule

/* hw/tcdm_subsystem.sv */
`include "hci_params.svh"

// TCDM subsystem top level.
// Two initiators share one memory path through the static multiplexer.
// The router and the four interleaved banks sit behind it, and the merger closes the loop.
module tcdm_subsystem (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       clear_i,
  input  logic [$clog2(`HCI_NB_CHAN)-1:0]            sel_i,
  input  logic [`HCI_NB_CHAN-1:0]                    in_req_i,
  input  logic [`HCI_NB_CHAN-1:0][`HCI_AW-1:0]       in_add_i,
  input  logic [`HCI_NB_CHAN-1:0]                    in_wen_i,
  input  logic [`HCI_NB_CHAN-1:0][`HCI_DW-1:0]       in_data_i,
  input  hci_req_pkg::tcdm_be_t [`HCI_NB_CHAN-1:0]   in_be_i,
  input  logic [`HCI_NB_CHAN-1:0][`HCI_UW-1:0]       in_user_i,
  output logic [`HCI_NB_CHAN-1:0]                    in_gnt_o,
  output logic [`HCI_NB_CHAN-1:0]                    in_r_valid_o,
  output logic [`HCI_NB_CHAN-1:0][`HCI_DW-1:0]       in_r_data_o,
  output hci_resp_pkg::tcdm_opc_e [`HCI_NB_CHAN-1:0] in_r_opc_o,
  output logic [`HCI_NB_CHAN-1:0][`HCI_UW-1:0]       in_r_user_o
);

  // Request bundle of the selected initiator.
  logic                  m_req;
  logic [`HCI_AW-1:0]    m_add;
  logic                  m_wen;
  logic [`HCI_DW-1:0]    m_data;
  hci_req_pkg::tcdm_be_t m_be;
  logic [`HCI_UW-1:0]    m_user;

  // Router outputs. The strobes are per bank and the rest is shared.
  logic [`HCI_NB_BANKS-1:0]          bank_req;
  logic [hci_req_pkg::ROW_W-1:0]     bank_row;
  logic                              bank_wen;
  logic [`HCI_DW-1:0]                bank_data;
  hci_req_pkg::tcdm_be_t             bank_be;
  logic [`HCI_UW-1:0]                bank_user;
  logic                              err_valid;
  logic [`HCI_UW-1:0]                err_user;

  // Bank responses, at most one of them valid per cycle.
  logic [`HCI_NB_BANKS-1:0]              b_r_valid;
  logic [`HCI_NB_BANKS-1:0][`HCI_DW-1:0] b_r_data;
  logic [`HCI_NB_BANKS-1:0][`HCI_UW-1:0] b_r_user;

  // Merged response on its way back through the multiplexer.
  logic                    r_valid;
  logic [`HCI_DW-1:0]      r_data;
  hci_resp_pkg::tcdm_opc_e r_opc;
  logic [`HCI_UW-1:0]      r_user;

  hci_core_mux_static hci_core_mux_static_i (
    .sel_i        ( sel_i        ),
    .in_req_i     ( in_req_i     ),
    .in_add_i     ( in_add_i     ),
    .in_wen_i     ( in_wen_i     ),
    .in_data_i    ( in_data_i    ),
    .in_be_i      ( in_be_i      ),
    .in_user_i    ( in_user_i    ),
    .in_gnt_o     ( in_gnt_o     ),
    .in_r_valid_o ( in_r_valid_o ),
    .in_r_data_o  ( in_r_data_o  ),
    .in_r_opc_o   ( in_r_opc_o   ),
    .in_r_user_o  ( in_r_user_o  ),
    .r_valid_i    ( r_valid      ),
    .r_data_i     ( r_data       ),
    .r_opc_i      ( r_opc        ),
    .r_user_i     ( r_user       ),
    .out_req_o    ( m_req        ),
    .out_add_o    ( m_add        ),
    .out_wen_o    ( m_wen        ),
    .out_data_o   ( m_data       ),
    .out_be_o     ( m_be         ),
    .out_user_o   ( m_user       )
  );

  // The flat address becomes the union view at the router port.
  tcdm_bank_router tcdm_bank_router_i (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .clear_i     ( clear_i   ),
    .req_i       ( m_req     ),
    .add_i       ( m_add     ),
    .wen_i       ( m_wen     ),
    .data_i      ( m_data    ),
    .be_i        ( m_be      ),
    .user_i      ( m_user    ),
    .bank_req_o  ( bank_req  ),
    .bank_row_o  ( bank_row  ),
    .bank_wen_o  ( bank_wen  ),
    .bank_data_o ( bank_data ),
    .bank_be_o   ( bank_be   ),
    .bank_user_o ( bank_user ),
    .err_valid_o ( err_valid ),
    .err_user_o  ( err_user  )
  );

  for (genvar bb = 0; bb < `HCI_NB_BANKS; bb++) begin : gen_bank
    tcdm_bank #(
      .DEPTH ( `HCI_BANK_DEPTH )
    ) tcdm_bank_i (
      .clk_i     ( clk_i         ),
      .rst_n_i   ( rst_n_i       ),
      .clear_i   ( clear_i       ),
      .req_i     ( bank_req[bb]  ),  // Only this strobe differs between banks.
      .row_i     ( bank_row      ),
      .wen_i     ( bank_wen      ),
      .data_i    ( bank_data     ),
      .be_i      ( bank_be       ),
      .user_i    ( bank_user     ),
      .r_valid_o ( b_r_valid[bb] ),
      .r_data_o  ( b_r_data[bb]  ),
      .r_user_o  ( b_r_user[bb]  )
    );
  end

  tcdm_resp_merge tcdm_resp_merge_i (
    .b_r_valid_i ( b_r_valid ),
    .b_r_data_i  ( b_r_data  ),
    .b_r_user_i  ( b_r_user  ),
    .err_valid_i ( err_valid ),
    .err_user_i  ( err_user  ),
    .r_valid_o   ( r_valid   ),
    .r_data_o    ( r_data    ),
    .r_opc_o     ( r_opc     ),
    .r_user_o    ( r_user    )
  );

endmodule

/* tb/tb_tcdm_subsystem.sv */
`include "hci_params.svh"

// Random testbench for the TCDM subsystem.
// A byte-array model of the whole memory predicts every response one cycle after acceptance.
module tb_tcdm_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NB_CHAN  = `HCI_NB_CHAN;
  localparam int CH_W     = $clog2(`HCI_NB_CHAN);
  localparam int BE_W     = `HCI_BE_W;
  localparam int NB_BANKS = `HCI_NB_BANKS;
  localparam int BANK_W   = $clog2(`HCI_NB_BANKS);
  localparam int WORDS    = `HCI_NB_BANKS * `HCI_BANK_DEPTH;  // 256 words in total.
  localparam int WORD_W   = $clog2(WORDS);                    // Bank and row bits together.
  localparam int OFF_W    = $clog2(`HCI_BE_W);
  localparam int UPPER_W  = `HCI_AW - WORD_W - OFF_W;

  localparam int RESET_CYCLES   = 10;
  localparam int PRELOAD_CYCLES = WORDS;  // One write per word.
  localparam int RANDOM_CYCLES  = 2000;
  localparam int DRAIN_CYCLES   = 4;
  localparam int RUN_CYCLES     = RESET_CYCLES + PRELOAD_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES + 2;
  // The run length rounded up to the next whole thousand cycles.
  localparam int CYCLE_LIMIT    = ((RUN_CYCLES + 999) / 1000) * 1000;

  localparam logic [31:0] SEED = 32'h35b3ff7c;

  // Expected response of one accepted request.
  typedef struct packed {
    logic [CH_W-1:0]    chan;  // Channel that must see r_valid.
    logic               err;   // Bad address gives OPC_ERR and zero data.
    logic [`HCI_DW-1:0] data;
    logic [`HCI_UW-1:0] user;
  } resp_t;

  logic                                       clk;
  logic                                       rst_n;
  logic                                       clear;
  logic [CH_W-1:0]                            sel;
  logic [`HCI_NB_CHAN-1:0]                    in_req;
  logic [`HCI_NB_CHAN-1:0][`HCI_AW-1:0]       in_add;
  logic [`HCI_NB_CHAN-1:0]                    in_wen;
  logic [`HCI_NB_CHAN-1:0][`HCI_DW-1:0]       in_data;
  hci_req_pkg::tcdm_be_t [`HCI_NB_CHAN-1:0]   in_be;
  logic [`HCI_NB_CHAN-1:0][`HCI_UW-1:0]       in_user;
  logic [`HCI_NB_CHAN-1:0]                    gnt;
  logic [`HCI_NB_CHAN-1:0]                    r_valid;
  logic [`HCI_NB_CHAN-1:0][`HCI_DW-1:0]       r_data;
  hci_resp_pkg::tcdm_opc_e [`HCI_NB_CHAN-1:0] r_opc;
  logic [`HCI_NB_CHAN-1:0][`HCI_UW-1:0]       r_user;

  logic [7:0]              mem_model [WORDS*BE_W];  // One entry per byte.
  resp_t                   exp_q [$];               // Holds at most one response.
  logic [NB_CHAN-1:0]      accepted_last;           // Request taken at the coming edge.
  logic [31:0]             lfsr_state;
  int                      value_errs;
  int                      proto_errs;
  int                      resp_count;
  int                      cycle_cnt;

  tcdm_subsystem tcdm_subsystem_i (
    .clk_i        ( clk     ),
    .rst_n_i      ( rst_n   ),
    .clear_i      ( clear   ),
    .sel_i        ( sel     ),
    .in_req_i     ( in_req  ),
    .in_add_i     ( in_add  ),
    .in_wen_i     ( in_wen  ),
    .in_data_i    ( in_data ),
    .in_be_i      ( in_be   ),
    .in_user_i    ( in_user ),
    .in_gnt_o     ( gnt     ),
    .in_r_valid_o ( r_valid ),
    .in_r_data_o  ( r_data  ),
    .in_r_opc_o   ( r_opc   ),
    .in_r_user_o  ( r_user  )
  );

  always #50 clk = ~clk;  // 100 ns period.

  // Galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Each bit taken costs one LFSR step.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Mostly good word addresses, with one in eight out of range and one in eight misaligned.
  function automatic logic [`HCI_AW-1:0] random_addr();
    logic [2:0]         kind;
    logic [WORD_W-1:0]  word;
    logic [UPPER_W-1:0] upper;
    logic [OFF_W-1:0]   offset;
    kind   = 3'(take_bits(3));
    word   = WORD_W'(take_bits(WORD_W));
    upper  = '0;
    offset = '0;
    if (kind == 3'd0) begin
      upper = UPPER_W'(take_bits(UPPER_W));
      if (upper == '0) begin
        upper = UPPER_W'(1);  // Keep it out of range.
      end
    end else if (kind == 3'd1) begin
      offset = OFF_W'(take_bits(OFF_W));
      if (offset == '0) begin
        offset = OFF_W'(1);
      end
    end
    return {upper, word, offset};
  endfunction

  function automatic logic addr_is_bad(input logic [`HCI_AW-1:0] a);
    return (a[`HCI_AW-1:WORD_W+OFF_W] != '0) || (a[OFF_W-1:0] != '0);
  endfunction

  // Applies one accepted request to the model and queues its response unless clear drops it.
  task automatic model_access(input logic [CH_W-1:0] chan, input logic [`HCI_AW-1:0] add,
                              input logic wen, input logic [`HCI_DW-1:0] data,
                              input hci_req_pkg::tcdm_be_t be,
                              input logic [`HCI_UW-1:0] user, input logic keep_resp);
    resp_t e;
    int    base;
    e.chan = chan;
    e.user = user;
    e.err  = addr_is_bad(add);
    e.data = '0;  // Writes and errors answer with zero.
    if (!e.err) begin
      base = int'(add[WORD_W+OFF_W-1:OFF_W]) * BE_W;
      for (int b = 0; b < BE_W; b++) begin
        if (wen) begin
          e.data[8*b +: 8] = mem_model[base+b];
        end else if (be[b]) begin
          mem_model[base+b] = data[8*b +: 8];  // Only enabled bytes change.
        end
      end
    end
    if (keep_resp) begin
      exp_q.push_back(e);
    end
  endtask

  // Runs at the falling edge, half a cycle after the response register changed.
  task automatic check_response(output logic seen);
    resp_t                   e;
    hci_resp_pkg::tcdm_opc_e exp_opc;
    seen = 1'b0;
    if (exp_q.size() != 0) begin
      e       = exp_q.pop_front();
      seen    = 1'b1;
      exp_opc = e.err ? hci_resp_pkg::OPC_ERR : hci_resp_pkg::OPC_OK;
      resp_count++;
      for (int c = 0; c < NB_CHAN; c++) begin
        assert (r_valid[c] === (e.chan == CH_W'(c))) else begin
          proto_errs++;
          $display("Protocol failure at %0d ns: r_valid %b on channel %0d, owner is channel %0d",
                   $time, r_valid[c], c, e.chan);
        end
        // Payload is broadcast, so every channel must carry it.
        assert (r_data[c] === e.data) else begin
          value_errs++;
          $display("[ERROR] %0d ns: channel %0d r_data %h, expected %h",
                   $time, c, r_data[c], e.data);
        end
        assert (r_opc[c] === exp_opc) else begin
          value_errs++;
          $display("[ERROR] %0d ns: channel %0d r_opc %b, expected %b",
                   $time, c, r_opc[c], exp_opc);
        end
        assert (r_user[c] === e.user) else begin
          value_errs++;
          $display("[ERROR] %0d ns: channel %0d r_user %h, expected %h",
                   $time, c, r_user[c], e.user);
        end
      end
    end else begin
      for (int c = 0; c < NB_CHAN; c++) begin
        assert (r_valid[c] === 1'b0) else begin
          proto_errs++;
          $display("Protocol failure at %0d ns: channel %0d raised r_valid with nothing accepted",
                   $time, c);
        end
      end
    end
  endtask

  // Runs just after the inputs were driven, while they stay steady until the rising edge.
  task automatic check_requests();
    logic                exp_gnt;
    logic [NB_BANKS-1:0] exp_strobe;
    exp_strobe = '0;
    for (int c = 0; c < NB_CHAN; c++) begin
      exp_gnt = (sel == CH_W'(c)) ? in_req[c] : 1'b0;  // Idle port is never granted.
      assert (gnt[c] === exp_gnt) else begin
        proto_errs++;
        $display("Protocol failure at %0d ns: channel %0d grant %b with request %b, select %0d",
                 $time, c, gnt[c], in_req[c], sel);
      end
      accepted_last[c] = exp_gnt;
    end
    // Word interleaving puts the bank index right above the byte offset.
    if (in_req[sel] && !addr_is_bad(in_add[sel])) begin
      exp_strobe[in_add[sel][OFF_W +: BANK_W]] = 1'b1;
    end
    assert (tcdm_subsystem_i.bank_req === exp_strobe) else begin
      value_errs++;
      $display("[ERROR] %0d ns: bank strobes %b for address %h, expected %b",
               $time, tcdm_subsystem_i.bank_req, in_add[sel], exp_strobe);
    end
    if (in_req[sel]) begin
      model_access(sel, in_add[sel], in_wen[sel], in_data[sel], in_be[sel], in_user[sel],
                   !clear);
    end
  endtask

  // A port keeps a refused request unchanged and draws a new one once it was taken.
  task automatic drive_channel(input int c);
    if (!in_req[c] || accepted_last[c]) begin
      in_req[c]  = (take_bits(2) != 0);  // Three in four cycles ask.
      in_wen[c]  = 1'(take_bits(1));
      in_add[c]  = random_addr();
      in_data[c] = take_bits(32);
      in_be[c]   = 4'(take_bits(BE_W));
      in_user[c] = 4'(take_bits(`HCI_UW));
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic seen;
    clk           = 1'b0;
    rst_n         = 1'b0;
    clear         = 1'b0;
    sel           = '0;
    in_req        = '0;
    in_add        = '0;
    in_wen        = '0;
    in_data       = '0;
    in_be         = '0;
    in_user       = '0;
    accepted_last = '0;
    lfsr_state    = SEED;
    value_errs    = 0;
    proto_errs    = 0;
    resp_count    = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Fill every word through channel 0 so that later reads are fully defined.
    for (int w = 0; w < WORDS; w++) begin
      @(negedge clk);
      check_response(seen);  // First pass also sees r_valid low after reset.
      in_req     = '0;
      in_req[0]  = 1'b1;
      in_wen[0]  = 1'b0;
      in_add[0]  = w * BE_W;
      in_data[0] = take_bits(32);
      in_be[0]   = '1;
      in_user[0] = 4'(take_bits(`HCI_UW));
      #1;
      check_requests();
    end

    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      @(negedge clk);
      check_response(seen);
      clear = (take_bits(5) == 0);
      // The select only moves while nothing is in flight.
      if (!seen) begin
        if (take_bits(3) == 0) begin
          sel = sel + 1'b1;
        end
      end
      for (int c = 0; c < NB_CHAN; c++) begin
        drive_channel(c);
      end
      #1;
      check_requests();
    end

    for (int d = 0; d < DRAIN_CYCLES; d++) begin
      @(negedge clk);
      check_response(seen);
      clear  = 1'b0;
      in_req = '0;
      #1;
      check_requests();
    end

    $display("Checked %0d responses, value errors %0d, protocol errors %0d",
             resp_count, value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
